/* hdl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // ----------------------------------------------------------
    // opcode field
    // ----------------------------------------------------------
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field, only meaningful under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // ----------------------------------------------------------
    // instruction word, two views of the same 32 bits
    // ----------------------------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

endpackage

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rdata1,
    output mips_pkg::word_t     rdata2
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            id_allowin,
    input  logic            br_taken,
    input  mips_pkg::word_t br_target,
    input  mips_pkg::word_t inst_sram_rdata,
    output logic            inst_sram_en,
    output mips_pkg::word_t inst_sram_addr,
    output logic            if_valid,
    output mips_pkg::word_t if_pc,
    output mips_pkg::word_t if_instr
);

    // address of the next request
    mips_pkg::word_t pc;
    // sram output belongs to the word in fetch this cycle
    logic            rdata_new;
    mips_pkg::word_t instr_buf;

    // one read per accepted slot and none in reset or while decode holds
    assign inst_sram_en   = !reset && id_allowin;
    assign inst_sram_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= RESET_PC;
            if_valid  <= 1'b0;
            rdata_new <= 1'b0;
        end else begin
            rdata_new <= id_allowin;
            if (id_allowin) begin
                // delay slot already requested, so redirect the one after it
                pc       <= br_taken ? br_target : pc + 32'd4;
                if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_allowin) begin
            if_pc <= pc;
        end
        if (rdata_new) begin
            instr_buf <= inst_sram_rdata;
        end
    end

    assign if_instr = rdata_new ? inst_sram_rdata : instr_buf;

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                if_valid,
    input  mips_pkg::word_t     if_pc,
    input  mips_pkg::word_t     if_instr,
    input  logic                exe_allowin,
    input  mips_pkg::reg_addr_t exe_dest,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::reg_addr_t wb_dest,
    input  logic                wb_we,
    input  mips_pkg::reg_addr_t wb_wnum,
    input  mips_pkg::word_t     wb_wdata,
    output logic                id_allowin,
    output logic                br_taken,
    output mips_pkg::word_t     br_target,
    output logic                id_valid,
    output mips_pkg::word_t     id_pc,
    output mips_pkg::alu_op_t   id_alu_op,
    output mips_pkg::word_t     id_src1,
    output mips_pkg::word_t     id_src2,
    output mips_pkg::word_t     id_store_data,
    output logic                id_is_load,
    output logic                id_is_store,
    output mips_pkg::reg_addr_t id_dest
);

    mips_pkg::instr_u    instr;
    logic [5:0]          opcode;
    logic [5:0]          funct;
    logic [15:0]         imm;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::word_t     rdata1;
    mips_pkg::word_t     rdata2;
    mips_pkg::word_t     ext_imm;
    mips_pkg::alu_op_t   alu_op;
    mips_pkg::reg_addr_t dest;
    logic                use_imm;
    logic                zext_imm;
    logic                reads_rt;
    logic                is_load;
    logic                is_store;
    logic                rs_hit;
    logic                rt_hit;
    logic                hazard;
    logic                to_exe;
    logic                br_cond;

    assign instr  = if_instr;
    assign opcode = instr.r_fields.opcode;
    assign rs     = instr.r_fields.rs;
    assign rt     = instr.r_fields.rt;
    assign rd     = instr.r_fields.rd;
    assign funct  = instr.r_fields.funct;
    assign imm    = instr.i_fields.imm;

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs),
        .raddr2 (rt),
        .we     (wb_we),
        .waddr  (wb_wnum),
        .wdata  (wb_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // ----------------------------------------------------------
    // instruction decode
    // ----------------------------------------------------------
    always_comb begin
        alu_op   = mips_pkg::ALU_ADD;
        dest     = '0;
        use_imm  = 1'b0;
        zext_imm = 1'b0;
        reads_rt = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                reads_rt = 1'b1;
                dest     = rd;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    // unknown funct runs as a nop
                    default:           dest = '0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                use_imm = 1'b1;
                dest    = rt;
            end
            mips_pkg::OP_ORI: begin
                alu_op   = mips_pkg::ALU_OR;
                use_imm  = 1'b1;
                zext_imm = 1'b1;
                dest     = rt;
            end
            mips_pkg::OP_LUI: begin
                alu_op   = mips_pkg::ALU_LUI;
                use_imm  = 1'b1;
                zext_imm = 1'b1;
                dest     = rt;
            end
            mips_pkg::OP_LW: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                dest    = rt;
            end
            mips_pkg::OP_SW: begin
                use_imm  = 1'b1;
                reads_rt = 1'b1;
                is_store = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                reads_rt = 1'b1;
            end
            default: begin
                dest = '0;
            end
        endcase
    end

    assign ext_imm = zext_imm ? {16'b0, imm} : {{16{imm[15]}}, imm};

    // ----------------------------------------------------------
    // dependence stall, no forwarding
    // ----------------------------------------------------------
    assign rs_hit = rs != '0 && (rs == exe_dest || rs == mem_dest || rs == wb_dest);
    assign rt_hit = reads_rt && rt != '0
                    && (rt == exe_dest || rt == mem_dest || rt == wb_dest);
    assign hazard = if_valid && (rs_hit || rt_hit);

    assign to_exe     = if_valid && !hazard;
    assign id_allowin = !if_valid || (!hazard && exe_allowin);

    // branch resolves here; target is relative to the delay slot
    assign br_cond   = (opcode == mips_pkg::OP_BEQ && rdata1 == rdata2)
                       || (opcode == mips_pkg::OP_BNE && rdata1 != rdata2);
    assign br_taken  = to_exe && exe_allowin && br_cond;
    assign br_target = if_pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (exe_allowin) begin
            id_valid <= to_exe;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_allowin) begin
            id_pc         <= if_pc;
            id_alu_op     <= alu_op;
            id_src1       <= rdata1;
            id_src2       <= use_imm ? ext_imm : rdata2;
            id_store_data <= rdata2;
            id_is_load    <= is_load;
            id_is_store   <= is_store;
            id_dest       <= dest;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                id_valid,
    input  mips_pkg::word_t     id_pc,
    input  mips_pkg::alu_op_t   id_alu_op,
    input  mips_pkg::word_t     id_src1,
    input  mips_pkg::word_t     id_src2,
    input  mips_pkg::word_t     id_store_data,
    input  logic                id_is_load,
    input  logic                id_is_store,
    input  mips_pkg::reg_addr_t id_dest,
    input  logic                mem_allowin,
    output logic                exe_allowin,
    output mips_pkg::reg_addr_t exe_dest,
    output logic                data_sram_en,
    output logic [3:0]          data_sram_wen,
    output mips_pkg::word_t     data_sram_addr,
    output mips_pkg::word_t     data_sram_wdata,
    output logic                exe_valid,
    output mips_pkg::word_t     exe_pc,
    output mips_pkg::word_t     exe_result,
    output logic                exe_is_load,
    output mips_pkg::reg_addr_t exe_wnum
);

    mips_pkg::word_t alu_result;
    logic            leaving;

    always_comb begin
        case (id_alu_op)
            mips_pkg::ALU_ADD: alu_result = id_src1 + id_src2;
            mips_pkg::ALU_SUB: alu_result = id_src1 - id_src2;
            mips_pkg::ALU_AND: alu_result = id_src1 & id_src2;
            mips_pkg::ALU_OR:  alu_result = id_src1 | id_src2;
            mips_pkg::ALU_SLT: alu_result = {31'b0, $signed(id_src1) < $signed(id_src2)};
            mips_pkg::ALU_LUI: alu_result = {id_src2[15:0], 16'b0};
            default:           alu_result = '0;
        endcase
    end

    // execute never stalls on its own
    assign exe_allowin = !id_valid || mem_allowin;
    assign leaving     = id_valid && mem_allowin;

    // stores and branches already carry dest 0 from decode
    assign exe_dest = id_valid ? id_dest : '0;

    // ----------------------------------------------------------
    // data sram request, word access only
    // ----------------------------------------------------------
    assign data_sram_en    = leaving && (id_is_load || id_is_store);
    assign data_sram_wen   = {4{leaving && id_is_store}};
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = id_store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (mem_allowin) begin
            exe_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_allowin) begin
            exe_pc      <= id_pc;
            exe_result  <= alu_result;
            exe_is_load <= id_is_load;
            exe_wnum    <= id_dest;
        end
    end

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                exe_valid,
    input  mips_pkg::word_t     exe_pc,
    input  mips_pkg::word_t     exe_result,
    input  logic                exe_is_load,
    input  mips_pkg::reg_addr_t exe_wnum,
    input  mips_pkg::word_t     data_sram_rdata,
    input  logic                wb_allowin,
    output logic                mem_allowin,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_valid,
    output mips_pkg::word_t     mem_pc,
    output mips_pkg::word_t     mem_result,
    output mips_pkg::reg_addr_t mem_wnum
);

    mips_pkg::word_t final_result;

    assign mem_allowin = !exe_valid || wb_allowin;
    assign mem_dest    = exe_valid ? exe_wnum : '0;

    // load data shows up one cycle after the request from execute
    assign final_result = exe_is_load ? data_sram_rdata : exe_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (wb_allowin) begin
            mem_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_allowin) begin
            mem_pc     <= exe_pc;
            mem_result <= final_result;
            mem_wnum   <= exe_wnum;
        end
    end

endmodule

`default_nettype wire

/* hdl/writeback_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_valid,
    input  mips_pkg::word_t     mem_pc,
    input  mips_pkg::word_t     mem_result,
    input  mips_pkg::reg_addr_t mem_wnum,
    output logic                wb_allowin,
    output mips_pkg::reg_addr_t wb_dest,
    output logic                wb_we,
    output mips_pkg::reg_addr_t wb_wnum,
    output mips_pkg::word_t     wb_wdata,
    output mips_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);

    // last stage, nothing downstream to wait for
    assign wb_allowin = 1'b1;
    assign wb_dest    = mem_valid ? mem_wnum : '0;

    // register file written at the end of this cycle
    assign wb_we    = mem_valid && mem_wnum != '0;
    assign wb_wnum  = mem_wnum;
    assign wb_wdata = mem_result;

    // trace registered, appears one cycle after the register file write
    always_ff @(posedge clk) begin
        if (reset) begin
            debug_wb_rf_wen <= 4'b0;
        end else begin
            debug_wb_rf_wen <= {4{wb_we}};
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_pc       <= mem_pc;
        debug_wb_rf_wnum  <= mem_wnum;
        debug_wb_rf_wdata <= mem_result;
    end

endmodule

`default_nettype wire

/* hdl/mips_core.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                reset,
    output logic                inst_sram_en,
    output mips_pkg::word_t     inst_sram_addr,
    input  mips_pkg::word_t     inst_sram_rdata,
    output logic                data_sram_en,
    output logic [3:0]          data_sram_wen,
    output mips_pkg::word_t     data_sram_addr,
    output mips_pkg::word_t     data_sram_wdata,
    input  mips_pkg::word_t     data_sram_rdata,
    output mips_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);

    // ----------------------------------------------------------
    // handshake and stage-to-stage nets, named as the ports
    // ----------------------------------------------------------
    logic                id_allowin;
    logic                exe_allowin;
    logic                mem_allowin;
    logic                wb_allowin;
    logic                br_taken;
    mips_pkg::word_t     br_target;

    logic                if_valid;
    mips_pkg::word_t     if_pc;
    mips_pkg::word_t     if_instr;

    logic                id_valid;
    mips_pkg::word_t     id_pc;
    mips_pkg::alu_op_t   id_alu_op;
    mips_pkg::word_t     id_src1;
    mips_pkg::word_t     id_src2;
    mips_pkg::word_t     id_store_data;
    logic                id_is_load;
    logic                id_is_store;
    mips_pkg::reg_addr_t id_dest;

    logic                exe_valid;
    mips_pkg::word_t     exe_pc;
    mips_pkg::word_t     exe_result;
    logic                exe_is_load;
    mips_pkg::reg_addr_t exe_wnum;

    logic                mem_valid;
    mips_pkg::word_t     mem_pc;
    mips_pkg::word_t     mem_result;
    mips_pkg::reg_addr_t mem_wnum;

    // destinations still in flight, for the decode stall
    mips_pkg::reg_addr_t exe_dest;
    mips_pkg::reg_addr_t mem_dest;
    mips_pkg::reg_addr_t wb_dest;

    logic                wb_we;
    mips_pkg::reg_addr_t wb_wnum;
    mips_pkg::word_t     wb_wdata;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    memory_stage u_memory (.*);

    writeback_stage u_writeback (.*);

endmodule

`default_nettype wire

/* tests/tb_programs.svh */
// instruction encoders, program images and expected traces
// included inside tb_mips_core, uses its memories and queues

// ----------------------------------------------------------
// MIPS32 opcode and funct codes
// ----------------------------------------------------------
localparam logic [5:0] op_beq   = 6'h04;
localparam logic [5:0] op_bne   = 6'h05;
localparam logic [5:0] op_addiu = 6'h09;
localparam logic [5:0] op_ori   = 6'h0d;
localparam logic [5:0] op_lui   = 6'h0f;
localparam logic [5:0] op_lw    = 6'h23;
localparam logic [5:0] op_sw    = 6'h2b;
localparam logic [5:0] fn_addu  = 6'h21;
localparam logic [5:0] fn_subu  = 6'h23;
localparam logic [5:0] fn_and   = 6'h24;
localparam logic [5:0] fn_or    = 6'h25;
localparam logic [5:0] fn_slt   = 6'h2a;

// operands in assembly order: rd, rs, rt
function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'h00, funct};
endfunction

// operands in assembly order: rt, rs, imm
function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// empty memory decodes as nops
task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
        imem[i] = 32'h0;
    end
    exp_pc.delete();
    exp_wnum.delete();
    exp_wdata.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
endtask

task automatic place(input int idx, input logic [31:0] word);
    imem[idx] = word;
endtask

// idx is the word offset of the writing instruction from reset_pc
task automatic expect_write(input int idx, input logic [4:0] wnum, input logic [31:0] wdata);
    exp_pc.push_back(reset_pc + 32'(idx * 4));
    exp_wnum.push_back(wnum);
    exp_wdata.push_back(wdata);
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_st_addr.push_back(addr);
    exp_st_data.push_back(data);
endtask

// ----------------------------------------------------------
// programs
// ----------------------------------------------------------
task automatic load_alu_program();
    clear_program();
    place(0, i_word(op_addiu, 5'd1, 5'd0, 16'h0005));
    place(1, i_word(op_addiu, 5'd2, 5'd0, 16'hfffd));
    place(2, i_word(op_ori, 5'd3, 5'd0, 16'h8001));
    place(3, i_word(op_lui, 5'd4, 5'd0, 16'hf00f));
    // slots 4 to 6 stay nops so the operands are settled
    place(7, r_word(fn_addu, 5'd5, 5'd1, 5'd2));
    place(8, r_word(fn_subu, 5'd6, 5'd1, 5'd2));
    place(9, r_word(fn_and, 5'd7, 5'd2, 5'd3));
    place(10, r_word(fn_or, 5'd8, 5'd3, 5'd4));
    place(11, r_word(fn_slt, 5'd9, 5'd2, 5'd1));
    place(12, r_word(fn_slt, 5'd10, 5'd1, 5'd2));
    expect_write(0, 5'd1, 32'h0000_0005);
    expect_write(1, 5'd2, 32'hffff_fffd);
    expect_write(2, 5'd3, 32'h0000_8001);
    expect_write(3, 5'd4, 32'hf00f_0000);
    expect_write(7, 5'd5, 32'h0000_0002);
    expect_write(8, 5'd6, 32'h0000_0008);
    expect_write(9, 5'd7, 32'h0000_8001);
    expect_write(10, 5'd8, 32'hf00f_8001);
    expect_write(11, 5'd9, 32'h0000_0001);
    expect_write(12, 5'd10, 32'h0000_0000);
endtask

task automatic load_hazard_program();
    clear_program();
    place(0, i_word(op_addiu, 5'd1, 5'd0, 16'h0001));
    place(1, r_word(fn_addu, 5'd1, 5'd1, 5'd1));
    place(2, r_word(fn_addu, 5'd2, 5'd1, 5'd1));
    place(3, r_word(fn_subu, 5'd3, 5'd2, 5'd1));
    // write to $0 is dropped
    place(4, i_word(op_addiu, 5'd0, 5'd3, 16'h0007));
    place(5, r_word(fn_addu, 5'd4, 5'd0, 5'd3));
    place(6, r_word(fn_addu, 5'd5, 5'd0, 5'd0));
    expect_write(0, 5'd1, 32'h0000_0001);
    expect_write(1, 5'd1, 32'h0000_0002);
    expect_write(2, 5'd2, 32'h0000_0004);
    expect_write(3, 5'd3, 32'h0000_0002);
    expect_write(5, 5'd4, 32'h0000_0002);
    expect_write(6, 5'd5, 32'h0000_0000);
endtask

task automatic load_memory_program();
    clear_program();
    place(0, i_word(op_lui, 5'd1, 5'd0, 16'h1234));
    place(1, i_word(op_ori, 5'd1, 5'd1, 16'h5678));
    place(2, i_word(op_sw, 5'd1, 5'd0, 16'h0040));
    place(3, i_word(op_lw, 5'd2, 5'd0, 16'h0040));
    // 0x80 holds the random preset word
    place(4, i_word(op_lw, 5'd3, 5'd0, 16'h0080));
    place(5, r_word(fn_addu, 5'd4, 5'd2, 5'd3));
    expect_write(0, 5'd1, 32'h1234_0000);
    expect_write(1, 5'd1, 32'h1234_5678);
    expect_write(3, 5'd2, 32'h1234_5678);
    expect_write(4, 5'd3, rand_word);
    expect_write(5, 5'd4, 32'h1234_5678 + rand_word);
    expect_store(32'h0000_0040, 32'h1234_5678);
endtask

task automatic load_branch_program();
    clear_program();
    place(0, i_word(op_addiu, 5'd1, 5'd0, 16'h0003));
    place(1, i_word(op_addiu, 5'd2, 5'd0, 16'h0003));
    // taken, target is slot 5
    place(2, i_word(op_beq, 5'd2, 5'd1, 16'h0002));
    place(3, i_word(op_addiu, 5'd3, 5'd0, 16'h0011));
    place(4, i_word(op_addiu, 5'd4, 5'd0, 16'h0022));
    // not taken, falls through after its delay slot
    place(5, i_word(op_bne, 5'd2, 5'd1, 16'h0003));
    place(6, i_word(op_addiu, 5'd5, 5'd0, 16'h0033));
    place(7, i_word(op_addiu, 5'd6, 5'd0, 16'h0044));
    expect_write(0, 5'd1, 32'h0000_0003);
    expect_write(1, 5'd2, 32'h0000_0003);
    expect_write(3, 5'd3, 32'h0000_0011);
    expect_write(6, 5'd5, 32'h0000_0033);
    expect_write(7, 5'd6, 32'h0000_0044);
endtask

/* tests/tb_mips_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] reset_pc     = 32'hbfc0_0000;
    localparam int          wait_limit   = 50;
    localparam int          quiet_cycles = 10;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic        inst_req;
    logic [31:0] inst_req_addr;
    logic        data_req;
    logic [31:0] data_req_addr;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_wnum [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    string       test_name;
    int          test_errors;
    int          passed;
    int          failed;
    integer      seed;
    logic [31:0] rand_word;

    `include "tb_programs.svh"

    mips_core #(
        .RESET_PC (reset_pc)
    ) i_mips_core (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ----------------------------------------------------------
    // SRAM models take the request on the rising edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        inst_req      <= inst_sram_en;
        inst_req_addr <= inst_sram_addr;
        data_req      <= data_sram_en;
        data_req_addr <= data_sram_addr;
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'h0;
            end
            // word at address 0x80
            dmem[8'h20] <= rand_word;
        end else if (data_sram_en && data_sram_wen != 4'b0) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    // read data goes out on the falling edge
    always @(negedge clk) begin
        if (inst_req) begin
            inst_sram_rdata <= imem[inst_req_addr[9:2]];
        end
        if (data_req) begin
            data_sram_rdata <= dmem[data_req_addr[9:2]];
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_idle_outputs();
        check_value("debug_wb_rf_wen", 32'h0, 32'(debug_wb_rf_wen));
        check_value("data_sram_wen", 32'h0, 32'(data_sram_wen));
        check_value("data_sram_en", 32'h0, 32'(data_sram_en));
    endtask

    task automatic check_store(inout int st_pos);
        if (data_sram_en && data_sram_wen != 4'b0) begin
            assert (st_pos < exp_st_addr.size()) else begin
                $display("%s wrote data memory at %h with no store pending",
                         test_name, data_sram_addr);
                test_errors++;
            end
            if (st_pos < exp_st_addr.size()) begin
                check_value("store wen", 32'hf, 32'(data_sram_wen));
                check_value("store addr", exp_st_addr[st_pos], data_sram_addr);
                check_value("store data", exp_st_data[st_pos], data_sram_wdata);
            end
            st_pos++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            passed++;
            $display("test %s passed", test_name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic check_reset_state();
        test_name = "reset";
        test_errors = 0;
        clear_program();
        reset = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        check_value("inst_sram_en", 32'h0, 32'(inst_sram_en));
        @(negedge clk);
        check_idle_outputs();
        check_value("inst_sram_en", 32'h0, 32'(inst_sram_en));
        reset = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        // request latched by the SRAM model at the first edge after reset
        check_value("first fetch en", 32'h1, 32'(inst_req));
        check_value("first fetch addr", reset_pc, inst_req_addr);
        finish_test();
    endtask

    // runs the loaded program and walks the trace in order
    task automatic run_program(input string name);
        int   st_pos;
        int   waited;
        logic timed_out;
        test_name = name;
        test_errors = 0;
        st_pos = 0;
        timed_out = 1'b0;
        apply_reset();
        for (int pos = 0; pos < exp_pc.size() && !timed_out; pos++) begin
            waited = 0;
            do begin
                @(negedge clk);
                check_store(st_pos);
                waited++;
            end while (debug_wb_rf_wen == 4'b0 && waited < wait_limit);
            if (debug_wb_rf_wen == 4'b0) begin
                $display("%s saw no register write %0d within %0d cycles",
                         name, pos, wait_limit);
                test_errors++;
                timed_out = 1'b1;
            end else begin
                check_value("pc", exp_pc[pos], debug_wb_pc);
                check_value("wnum", 32'(exp_wnum[pos]), 32'(debug_wb_rf_wnum));
                check_value("wdata", exp_wdata[pos], debug_wb_rf_wdata);
                check_value("wen", 32'hf, 32'(debug_wb_rf_wen));
            end
        end
        // only nops follow so nothing more may be written
        repeat (quiet_cycles) begin
            @(negedge clk);
            check_store(st_pos);
            check_value("late wen", 32'h0, 32'(debug_wb_rf_wen));
        end
        assert (st_pos >= exp_st_addr.size()) else begin
            $display("%s issued %0d stores but %0d were due", name, st_pos,
                     exp_st_addr.size());
            test_errors++;
        end
        finish_test();
    endtask

    initial begin
        reset = 1'b1;
        passed = 0;
        failed = 0;
        seed = 32'h7779_c6ae;
        rand_word = $random(seed);
        check_reset_state();
        load_alu_program();
        run_program("alu");
        load_hazard_program();
        run_program("hazard");
        load_memory_program();
        run_program("memory");
        load_branch_program();
        run_program("branch");
        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+tests
hdl/mips_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/writeback_stage.sv
hdl/mips_core.sv
tests/tb_mips_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mips_core -f files.f -o tb_mips_core

output="$(./obj_dir/tb_mips_core)"
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1
